/* source/icache_cfg.svh */
//////////////////////////////
// Address, request field, line and slot sizes of the instruction cache
//////////////////////////////

`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Request fields from the CPU side
`define ICACHE_ADDR_W 32
`define ICACHE_ID_W 4
`define ICACHE_PROT_W 3
// One instruction word
`define ICACHE_ILEN 32
// Line geometry, 16 bytes per line
`define ICACHE_LINE_W 128
`define ICACHE_OFFSET_W 4
`define ICACHE_WORD_SEL_W 2
`define ICACHE_TAG_W 28
// Fully associative slot count
`define ICACHE_NUM_SLOTS 4

`endif

/* source/icache_pkg.sv */
//////////////////////////////
// Cache address type, decoded raw or as tag, word and byte fields
//////////////////////////////

`include "icache_cfg.svh"

package icache_pkg;

    //////////////////////////////
    // Address decode
    //////////////////////////////

    // One address word seen in two ways
    // Raw view for arithmetic, field view for tag and word index
    typedef union packed {
        logic [`ICACHE_ADDR_W-1:0] raw;
        struct packed {
            // Line tag, address without the line offset
            logic [`ICACHE_TAG_W-1:0]                         tag;
            // Word within the line
            logic [`ICACHE_WORD_SEL_W-1:0]                    word;
            // Byte within the word
            logic [`ICACHE_OFFSET_W-`ICACHE_WORD_SEL_W-1:0]   byte_off;
        } f;
    } icache_addr_t;

endpackage

/* source/icache_line_slot.sv */
//////////////////////////////
// One cache line slot with valid, tag, data and tag compare
//////////////////////////////

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_line_slot (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      srst,
    // Fill side
    input  logic                      slot_wr,
    input  logic [`ICACHE_TAG_W-1:0]  fill_tag,
    input  logic [`ICACHE_LINE_W-1:0] fill_data,
    // Lookup side
    input  logic [`ICACHE_TAG_W-1:0]  lookup_tag,
    output logic                      slot_hit,
    output logic [`ICACHE_LINE_W-1:0] slot_data
);

    // Line state
    logic                      valid_q;
    logic [`ICACHE_TAG_W-1:0]  tag_q;
    logic [`ICACHE_LINE_W-1:0] data_q;

    // Valid set by a fill, cleared by either reset
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            valid_q <= 1'b0;
        end else if (srst) begin
            valid_q <= 1'b0;
        end else if (slot_wr) begin
            valid_q <= 1'b1;
        end
    end

    // Tag and line payload loaded together
    always_ff @(posedge aclk) begin
        if (slot_wr) begin
            tag_q  <= fill_tag;
            data_q <= fill_data;
        end
    end

    // Match is combinational so the lookup registers in the selector
    assign slot_hit  = valid_q && (tag_q == lookup_tag);
    assign slot_data = data_q;

endmodule

/* source/icache_fill_router.sv */
//////////////////////////////
// Fill router, writes each memory completion to the next slot in turn
//////////////////////////////

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_fill_router (
    input  logic                         aclk,
    input  logic                         aresetn,
    input  logic                         srst,
    // Memory read request, observed only
    input  logic                         memctrl_arvalid,
    input  logic                         memctrl_arready,
    input  logic [`ICACHE_ADDR_W-1:0]    memctrl_araddr,
    // Line completion
    input  logic                         mem_cpl_wr,
    input  logic [`ICACHE_LINE_W-1:0]    mem_cpl_data,
    // Slot write port
    output logic [`ICACHE_NUM_SLOTS-1:0] slot_wr,
    output logic [`ICACHE_TAG_W-1:0]     fill_tag,
    output logic [`ICACHE_LINE_W-1:0]    fill_data
);

    import icache_pkg::*;

    localparam int PTR_W = $clog2(`ICACHE_NUM_SLOTS);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(`ICACHE_NUM_SLOTS - 1);

    icache_addr_t     req_addr;
    logic [PTR_W-1:0] ptr_q;
    logic [`ICACHE_TAG_W-1:0] tag_q;

    //////////////////////////////
    // Tag capture
    //////////////////////////////

    assign req_addr.raw = memctrl_araddr;

    // Only one request is outstanding, so one tag register is enough
    always_ff @(posedge aclk) begin
        if (memctrl_arvalid && memctrl_arready) begin
            tag_q <= req_addr.f.tag;
        end
    end

    //////////////////////////////
    // Round-robin pointer
    //////////////////////////////

    // Moves on after every completion, wraps after the last slot
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            ptr_q <= '0;
        end else if (srst) begin
            ptr_q <= '0;
        end else if (mem_cpl_wr) begin
            ptr_q <= (ptr_q == LAST_SLOT) ? '0 : ptr_q + 1'b1;
        end
    end

    // One-hot strobe to the current slot, same cycle as the completion
    assign slot_wr   = mem_cpl_wr ? (`ICACHE_NUM_SLOTS'(1) << ptr_q) : '0;
    assign fill_tag  = tag_q;
    assign fill_data = mem_cpl_data;

endmodule

/* source/icache_hit_select.sv */
//////////////////////////////
// Hit selector, registers the lookup result and picks the read word
//////////////////////////////

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_hit_select (
    input  logic                                             aclk,
    input  logic                                             aresetn,
    input  logic                                             srst,
    // CPU read request
    input  logic                                             cache_ren,
    input  logic [`ICACHE_ADDR_W-1:0]                        cache_raddr,
    input  logic [`ICACHE_ID_W-1:0]                          cache_rid,
    input  logic [`ICACHE_PROT_W-1:0]                        cache_rprot,
    // Slot results
    input  logic [`ICACHE_NUM_SLOTS-1:0]                     slot_hit,
    input  logic [`ICACHE_NUM_SLOTS-1:0][`ICACHE_LINE_W-1:0] slot_data,
    output logic [`ICACHE_TAG_W-1:0]                         lookup_tag,
    // CPU response
    output logic                                             cache_rvalid,
    output logic                                             cache_hit,
    output logic                                             cache_miss,
    output logic [`ICACHE_ILEN-1:0]                          cache_rdata,
    output logic [`ICACHE_ID_W-1:0]                          cache_rsp_id,
    // Buffered request for the prefetcher
    output logic [`ICACHE_ADDR_W-1:0]                        req_addr_q,
    output logic [`ICACHE_ID_W-1:0]                          req_id_q,
    output logic [`ICACHE_PROT_W-1:0]                        req_prot_q
);

    import icache_pkg::*;

    icache_addr_t              rd_addr;
    logic                      any_hit;
    logic [`ICACHE_LINE_W-1:0] hit_line;
    logic [`ICACHE_ILEN-1:0]   hit_word;

    assign rd_addr.raw = cache_raddr;
    assign lookup_tag  = rd_addr.f.tag;
    assign any_hit     = |slot_hit;

    // OR of the hitting lines, duplicates hold the same data
    always_comb begin
        hit_line = '0;
        for (int i = 0; i < `ICACHE_NUM_SLOTS; i++) begin
            if (slot_hit[i]) begin
                hit_line = hit_line | slot_data[i];
            end
        end
    end

    assign hit_word = hit_line[rd_addr.f.word * `ICACHE_ILEN +: `ICACHE_ILEN];

    // Response flags, one cycle after the request
    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            cache_rvalid <= 1'b0;
            cache_hit    <= 1'b0;
            cache_miss   <= 1'b0;
        end else if (srst) begin
            cache_rvalid <= 1'b0;
            cache_hit    <= 1'b0;
            cache_miss   <= 1'b0;
        end else begin
            cache_rvalid <= cache_ren;
            cache_hit    <= cache_ren && any_hit;
            cache_miss   <= cache_ren && !any_hit;
        end
    end

    // Read word and ID, zero data on a miss
    always_ff @(posedge aclk) begin
        cache_rdata  <= (cache_ren && any_hit) ? hit_word : '0;
        cache_rsp_id <= cache_rid;
    end

    // Held request, what a miss will fetch
    always_ff @(posedge aclk) begin
        if (cache_ren) begin
            req_addr_q <= cache_raddr;
            req_id_q   <= cache_rid;
            req_prot_q <= cache_rprot;
        end
    end

endmodule

/* source/icache_prefetcher.sv */
//////////////////////////////
// Prefetcher, fetches the missed line then the next sequential line
//////////////////////////////

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_prefetcher (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      srst,
    // Registered lookup outcome
    input  logic                      cache_miss,
    input  logic [`ICACHE_ADDR_W-1:0] req_addr_q,
    input  logic [`ICACHE_ID_W-1:0]   req_id_q,
    input  logic [`ICACHE_PROT_W-1:0] req_prot_q,
    // Memory read request
    output logic                      memctrl_arvalid,
    output logic [`ICACHE_ADDR_W-1:0] memctrl_araddr,
    output logic [`ICACHE_PROT_W-1:0] memctrl_arprot,
    output logic [`ICACHE_ID_W-1:0]   memctrl_arid,
    input  logic                      memctrl_arready,
    // Line completion
    input  logic                      mem_cpl_wr,
    // Status to the CPU side
    output logic                      block_fill,
    output logic                      cache_ready
);

    import icache_pkg::*;

    //////////////////////////////
    // Sequencer encoding
    //////////////////////////////

    // Waiting for a miss
    localparam logic [1:0] ST_IDLE  = 2'd0;
    // Demanded line requested, waiting for its completion
    localparam logic [1:0] ST_LOAD  = 2'd1;
    // Demanded line written, block_fill high this cycle
    localparam logic [1:0] ST_FETCH = 2'd2;
    // Next line requested, waiting for its completion
    localparam logic [1:0] ST_PREF  = 2'd3;

    // Byte distance between two lines
    localparam logic [`ICACHE_ADDR_W-1:0] LINE_BYTES = `ICACHE_LINE_W / 8;

    logic [1:0]   state_q;
    icache_addr_t miss_addr;
    icache_addr_t line_addr;
    logic [`ICACHE_ADDR_W-1:0] next_addr_q;
    logic         start_miss;
    logic         start_next;

    //////////////////////////////
    // Address building
    //////////////////////////////

    assign miss_addr.raw = req_addr_q;

    // Clear word and byte fields to align on the line
    always_comb begin
        line_addr            = miss_addr;
        line_addr.f.word     = '0;
        line_addr.f.byte_off = '0;
    end

    // Misses while busy are dropped
    assign start_miss = (state_q == ST_IDLE) && cache_miss;
    assign start_next = (state_q == ST_FETCH);

    //////////////////////////////
    // Control sequencer
    //////////////////////////////

    always_ff @(posedge aclk or negedge aresetn) begin
        if (!aresetn) begin
            state_q         <= ST_IDLE;
            memctrl_arvalid <= 1'b0;
            block_fill      <= 1'b0;
        end else if (srst) begin
            state_q         <= ST_IDLE;
            memctrl_arvalid <= 1'b0;
            block_fill      <= 1'b0;
        end else begin
            // Request retires on the handshake, whatever the state
            if (memctrl_arvalid && memctrl_arready) begin
                memctrl_arvalid <= 1'b0;
            end
            block_fill <= 1'b0;

            case (state_q)
                ST_IDLE: begin
                    if (start_miss) begin
                        memctrl_arvalid <= 1'b1;
                        state_q         <= ST_LOAD;
                    end
                end
                ST_LOAD: begin
                    // Demanded line is in its slot from this edge on
                    if (mem_cpl_wr) begin
                        block_fill <= 1'b1;
                        state_q    <= ST_FETCH;
                    end
                end
                ST_FETCH: begin
                    memctrl_arvalid <= 1'b1;
                    state_q         <= ST_PREF;
                end
                default: begin
                    // Speculative line lands silently
                    if (mem_cpl_wr) begin
                        state_q <= ST_IDLE;
                    end
                end
            endcase
        end
    end

    // Request fields, stable while arvalid is high
    always_ff @(posedge aclk) begin
        if (start_miss) begin
            memctrl_araddr <= line_addr.raw;
            memctrl_arid   <= req_id_q;
            memctrl_arprot <= req_prot_q;
            next_addr_q    <= line_addr.raw + LINE_BYTES;
        end else if (start_next) begin
            // Same ID and protection as the demanded line
            memctrl_araddr <= next_addr_q;
        end
    end

    // Busy from the first request until the prefetch returns
    assign cache_ready = (state_q == ST_IDLE);

endmodule

/* source/icache_top.sv */
//////////////////////////////
// Instruction cache front end, prefetcher, fill router, slots, selector
//////////////////////////////

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_top (
    input  logic                      aclk,
    input  logic                      aresetn,
    input  logic                      srst,
    // CPU read side
    input  logic                      cache_ren,
    input  logic [`ICACHE_ADDR_W-1:0] cache_raddr,
    input  logic [`ICACHE_ID_W-1:0]   cache_rid,
    input  logic [`ICACHE_PROT_W-1:0] cache_rprot,
    output logic                      cache_ready,
    output logic                      cache_rvalid,
    output logic                      cache_hit,
    output logic                      cache_miss,
    output logic [`ICACHE_ILEN-1:0]   cache_rdata,
    output logic [`ICACHE_ID_W-1:0]   cache_rsp_id,
    // Memory read request
    output logic                      memctrl_arvalid,
    input  logic                      memctrl_arready,
    output logic [`ICACHE_ADDR_W-1:0] memctrl_araddr,
    output logic [`ICACHE_PROT_W-1:0] memctrl_arprot,
    output logic [`ICACHE_ID_W-1:0]   memctrl_arid,
    // Memory completion
    input  logic                      mem_cpl_wr,
    input  logic [`ICACHE_LINE_W-1:0] mem_cpl_data,
    input  logic [`ICACHE_ID_W-1:0]   mem_cpl_rid,
    // Demanded line written
    output logic                      block_fill
);

    logic                                             cpl_wr;
    logic [`ICACHE_NUM_SLOTS-1:0]                     slot_wr;
    logic [`ICACHE_TAG_W-1:0]                         fill_tag;
    logic [`ICACHE_LINE_W-1:0]                        fill_data;
    logic [`ICACHE_TAG_W-1:0]                         lookup_tag;
    logic [`ICACHE_NUM_SLOTS-1:0]                     slot_hit;
    logic [`ICACHE_NUM_SLOTS-1:0][`ICACHE_LINE_W-1:0] slot_data;
    logic [`ICACHE_ADDR_W-1:0]                        req_addr_q;
    logic [`ICACHE_ID_W-1:0]                          req_id_q;
    logic [`ICACHE_PROT_W-1:0]                        req_prot_q;

    // Completions echo the request ID, arid holds it until the next request
    assign cpl_wr = mem_cpl_wr && (mem_cpl_rid == memctrl_arid);

    //////////////////////////////
    // Lookup and response
    //////////////////////////////

    icache_hit_select u_hit_select (
        .aclk         (aclk),
        .aresetn      (aresetn),
        .srst         (srst),
        .cache_ren    (cache_ren),
        .cache_raddr  (cache_raddr),
        .cache_rid    (cache_rid),
        .cache_rprot  (cache_rprot),
        .slot_hit     (slot_hit),
        .slot_data    (slot_data),
        .lookup_tag   (lookup_tag),
        .cache_rvalid (cache_rvalid),
        .cache_hit    (cache_hit),
        .cache_miss   (cache_miss),
        .cache_rdata  (cache_rdata),
        .cache_rsp_id (cache_rsp_id),
        .req_addr_q   (req_addr_q),
        .req_id_q     (req_id_q),
        .req_prot_q   (req_prot_q)
    );

    //////////////////////////////
    // Miss and prefetch requests
    //////////////////////////////

    icache_prefetcher u_prefetcher (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .srst            (srst),
        .cache_miss      (cache_miss),
        .req_addr_q      (req_addr_q),
        .req_id_q        (req_id_q),
        .req_prot_q      (req_prot_q),
        .memctrl_arvalid (memctrl_arvalid),
        .memctrl_araddr  (memctrl_araddr),
        .memctrl_arprot  (memctrl_arprot),
        .memctrl_arid    (memctrl_arid),
        .memctrl_arready (memctrl_arready),
        .mem_cpl_wr      (cpl_wr),
        .block_fill      (block_fill),
        .cache_ready     (cache_ready)
    );

    // Round-robin slot fill
    icache_fill_router u_fill_router (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .srst            (srst),
        .memctrl_arvalid (memctrl_arvalid),
        .memctrl_arready (memctrl_arready),
        .memctrl_araddr  (memctrl_araddr),
        .mem_cpl_wr      (cpl_wr),
        .mem_cpl_data    (mem_cpl_data),
        .slot_wr         (slot_wr),
        .fill_tag        (fill_tag),
        .fill_data       (fill_data)
    );

    //////////////////////////////
    // Line slots
    //////////////////////////////

    for (genvar i = 0; i < `ICACHE_NUM_SLOTS; i++) begin : g_slot
        icache_line_slot u_slot (
            .aclk       (aclk),
            .aresetn    (aresetn),
            .srst       (srst),
            .slot_wr    (slot_wr[i]),
            .fill_tag   (fill_tag),
            .fill_data  (fill_data),
            .lookup_tag (lookup_tag),
            .slot_hit   (slot_hit[i]),
            .slot_data  (slot_data[i])
        );
    end

endmodule

/* test/icache_tb.sv */
//////////////////////////////
// Instruction cache testbench with clock, reset, memory model and timeout
// Reads and expected hit flags come from the data file
//////////////////////////////

`timescale 1ns/1ns
`include "icache_cfg.svh"

module icache_tb;

    localparam int MAX_ENTRIES      = 64;
    localparam int CYCLES_PER_ENTRY = 60;
    localparam logic [31:0] END_MARK  = 32'hffff_ffff;
    localparam logic [31:0] DATA_KEY  = 32'h5a5a_0000;
    // Taps for x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_POLY = 32'h8020_0003;

    logic                      aclk;
    logic                      aresetn;
    logic                      srst;
    logic                      cache_ren;
    logic [`ICACHE_ADDR_W-1:0] cache_raddr;
    logic [`ICACHE_ID_W-1:0]   cache_rid;
    logic [`ICACHE_PROT_W-1:0] cache_rprot;
    logic                      cache_ready;
    logic                      cache_rvalid;
    logic                      cache_hit;
    logic                      cache_miss;
    logic [`ICACHE_ILEN-1:0]   cache_rdata;
    logic [`ICACHE_ID_W-1:0]   cache_rsp_id;
    logic                      memctrl_arvalid;
    logic                      memctrl_arready;
    logic [`ICACHE_ADDR_W-1:0] memctrl_araddr;
    logic [`ICACHE_PROT_W-1:0] memctrl_arprot;
    logic [`ICACHE_ID_W-1:0]   memctrl_arid;
    logic                      mem_cpl_wr;
    logic [`ICACHE_LINE_W-1:0] mem_cpl_data;
    logic [`ICACHE_ID_W-1:0]   mem_cpl_rid;
    logic                      block_fill;

    // Each entry holds an address, a hit flag and an srst flag
    logic [31:0] testdata [0:3*MAX_ENTRIES-1];
    logic [31:0] lfsr_state = 32'h0f97_5f9a;
    int num_entries;
    int timeout_cycles = 0;
    int cycle_count = 0;
    int fill_count = 0;
    // Accepted memory requests in arrival order
    logic [`ICACHE_ADDR_W-1:0] req_addr_log [$];
    logic [`ICACHE_ID_W-1:0]   req_id_log [$];
    logic [`ICACHE_PROT_W-1:0] req_prot_log [$];

    icache_top UUT (
        .aclk            (aclk),
        .aresetn         (aresetn),
        .srst            (srst),
        .cache_ren       (cache_ren),
        .cache_raddr     (cache_raddr),
        .cache_rid       (cache_rid),
        .cache_rprot     (cache_rprot),
        .cache_ready     (cache_ready),
        .cache_rvalid    (cache_rvalid),
        .cache_hit       (cache_hit),
        .cache_miss      (cache_miss),
        .cache_rdata     (cache_rdata),
        .cache_rsp_id    (cache_rsp_id),
        .memctrl_arvalid (memctrl_arvalid),
        .memctrl_arready (memctrl_arready),
        .memctrl_araddr  (memctrl_araddr),
        .memctrl_arprot  (memctrl_arprot),
        .memctrl_arid    (memctrl_arid),
        .mem_cpl_wr      (mem_cpl_wr),
        .mem_cpl_data    (mem_cpl_data),
        .mem_cpl_rid     (mem_cpl_rid),
        .block_fill      (block_fill)
    );

    always #5 aclk = ~aclk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois step giving one output bit per call
    function automatic logic lfsr_next_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ LFSR_POLY;
        end
        return out_bit;
    endfunction

    function automatic int random_bits(input int width);
        int value;
        value = 0;
        for (int i = 0; i < width; i++) begin
            value = (value << 1) | int'(lfsr_next_bit());
        end
        return value;
    endfunction

    // Word at byte address A holds A xor the key
    function automatic logic [31:0] word_at(input logic [31:0] addr);
        return {addr[31:2], 2'b00} ^ DATA_KEY;
    endfunction

    // Word 0 in the low bits of the line
    function automatic logic [`ICACHE_LINE_W-1:0] line_data(input logic [31:0] base);
        logic [`ICACHE_LINE_W-1:0] line;
        for (int w = 0; w < 4; w++) begin
            line[w*32 +: 32] = word_at(base + 32'(4 * w));
        end
        return line;
    endfunction

    task automatic abort_run();
        $display("=== FAIL ===");
        $fatal(1, "Simulation stopped on the first error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            abort_run();
        end
    endtask

    // Starts and ends on a falling edge
    task automatic read_and_check(input logic [31:0] addr, input logic [3:0] id,
                                  input logic [2:0] prot, input logic expect_hit);
        while (!cache_ready) begin
            @(negedge aclk);
        end
        cache_ren   = 1'b1;
        cache_raddr = addr;
        cache_rid   = id;
        cache_rprot = prot;
        @(negedge aclk);
        cache_ren = 1'b0;
        check_value(32'(cache_rvalid), 1, "rvalid one cycle after ren");
        check_value(32'(cache_hit), 32'(expect_hit), "hit flag");
        check_value(32'(cache_miss), 32'(!expect_hit), "miss flag");
        check_value(32'(cache_rsp_id), 32'(id), "response ID");
        check_value(cache_rdata, expect_hit ? word_at(addr) : 32'h0, "read data");
        @(negedge aclk);
        check_value(32'(cache_rvalid), 0, "rvalid lasts one cycle");
        if (expect_hit) begin
            check_value(32'(memctrl_arvalid), 0, "no memory request on a hit");
        end
    endtask

    task automatic clear_cache();
        srst = 1'b1;
        @(negedge aclk);
        srst = 1'b0;
        @(negedge aclk);
        check_value(32'(cache_ready), 1, "ready after srst");
        check_value(32'(memctrl_arvalid), 0, "arvalid after srst");
    endtask

    //////////////////////////////
    // Memory and monitors
    //////////////////////////////

    // Serves one request at a time with random arready and completion delays
    initial begin : memory_model
        int delay;
        logic [31:0] line_addr;
        logic [3:0]  line_id;
        memctrl_arready = 1'b0;
        mem_cpl_wr      = 1'b0;
        mem_cpl_data    = '0;
        mem_cpl_rid     = '0;
        forever begin
            @(negedge aclk);
            if (memctrl_arvalid) begin
                delay = random_bits(2);
                repeat (delay) @(negedge aclk);
                line_addr = memctrl_araddr;
                line_id   = memctrl_arid;
                req_addr_log.push_back(memctrl_araddr);
                req_id_log.push_back(memctrl_arid);
                req_prot_log.push_back(memctrl_arprot);
                // Handshake on the next rising edge
                memctrl_arready = 1'b1;
                @(negedge aclk);
                memctrl_arready = 1'b0;
                delay = random_bits(2) + 1;
                repeat (delay - 1) @(negedge aclk);
                mem_cpl_wr   = 1'b1;
                mem_cpl_data = line_data(line_addr);
                mem_cpl_rid  = line_id;
                @(negedge aclk);
                mem_cpl_wr = 1'b0;
            end
        end
    end

    always @(negedge aclk) begin
        if (aresetn && block_fill) begin
            fill_count <= fill_count + 1;
        end
    end

    always @(posedge aclk) begin
        cycle_count <= cycle_count + 1;
        if (timeout_cycles > 0 && cycle_count >= timeout_cycles) begin
            $display("Timeout, the run did not finish within %0d cycles", timeout_cycles);
            abort_run();
        end
    end

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin : main
        logic [31:0] addr;
        logic [31:0] line_addr;
        logic        expect_hit;
        logic [3:0]  id;
        logic [2:0]  prot;
        int          req_before;
        int          fill_before;
        aclk        = 1'b0;
        aresetn     = 1'b0;
        srst        = 1'b0;
        cache_ren   = 1'b0;
        cache_raddr = '0;
        cache_rid   = '0;
        cache_rprot = '0;
        $readmemh("test/icache_testdata.txt", testdata);
        num_entries = 0;
        while (num_entries < MAX_ENTRIES && testdata[3*num_entries] != END_MARK) begin
            num_entries++;
        end
        if (num_entries == 0 || num_entries == MAX_ENTRIES) begin
            $display("The data file has no entries or no end marker");
            abort_run();
        end
        timeout_cycles = CYCLES_PER_ENTRY * num_entries;

        repeat (8) @(posedge aclk);
        @(negedge aclk);
        aresetn = 1'b1;
        @(negedge aclk);
        check_value(32'(memctrl_arvalid), 0, "arvalid after reset");
        check_value(32'(block_fill), 0, "block_fill after reset");
        check_value(32'(cache_rvalid), 0, "rvalid after reset");
        check_value(32'(cache_ready), 1, "ready after reset");

        for (int idx = 0; idx < num_entries; idx++) begin
            addr       = testdata[3*idx];
            expect_hit = testdata[3*idx+1][0];
            id         = 4'(idx);
            prot       = 3'(idx + 5);
            line_addr  = {addr[31:4], 4'h0};
            if (testdata[3*idx+2][0]) begin
                clear_cache();
            end
            req_before  = req_addr_log.size();
            fill_before = fill_count;
            read_and_check(addr, id, prot, expect_hit);
            if (!expect_hit) begin
                while (!block_fill) begin
                    @(negedge aclk);
                end
                check_value(32'(req_addr_log.size()), 32'(req_before + 1), "demand request count");
                check_value(req_addr_log[req_before], line_addr, "demand request address");
                check_value(32'(req_id_log[req_before]), 32'(id), "demand request ID");
                check_value(32'(req_prot_log[req_before]), 32'(prot), "demand request prot");
                // Re-read after the fill
                read_and_check(addr, id, prot, 1'b1);
                check_value(32'(req_addr_log.size()), 32'(req_before + 2), "prefetch request count");
                check_value(req_addr_log[req_before+1], line_addr + 32'd16, "prefetch address");
                check_value(32'(req_id_log[req_before+1]), 32'(id), "prefetch request ID");
                check_value(32'(req_prot_log[req_before+1]), 32'(prot), "prefetch request prot");
                check_value(32'(fill_count), 32'(fill_before + 1), "block_fill pulses per miss");
            end
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule

/* test/icache_testdata.txt */
// Read address, expected hit flag, srst pulse before the read
// Hex values, the address ffffffff marks the end of the list
00001000 0 0
00001014 1 0
00001008 1 0
00002004 0 0
0000201c 1 0
0000100c 1 0
00003000 0 0
00001000 0 0
00002008 0 0
00001018 1 0
00003004 0 0
00003014 1 0
00002010 1 0
00004000 0 0
0000300c 1 0
00004018 1 0
00004000 0 1
00004010 1 0
00003000 0 0
0000fff0 0 0
00010004 1 0
00004000 0 0
ffffffff 0 0

/* icache_top.f */
+incdir+source
source/icache_pkg.sv
source/icache_line_slot.sv
source/icache_fill_router.sv
source/icache_hit_select.sv
source/icache_prefetcher.sv
source/icache_top.sv
test/icache_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module icache_tb -f icache_top.f

# A failing run exits non-zero, so keep its output for the search below
output=$(./obj_dir/Vicache_tb) || true
echo "$output"

if echo "$output" | grep -q "=== PASS ==="; then
    exit 0
else
    exit 1
fi
